/* include/gat_consts.svh */
`ifndef GAT_CONSTS_SVH
`define GAT_CONSTS_SVH

// column index width, the weight table is indexed by it.
`define GAT_COL_W       4
`define GAT_TAB_SIZE    16

// signed value and weight width.
`define GAT_VAL_W       8

// row accumulator and row result, signed.
`define GAT_ACC_W       24

// final node feature, signed.
`define GAT_OUT_W       16

`define GAT_FIFO_DEPTH  4

// debug monitor counter width and the row whose feature is kept.
`define GAT_CNT_W       16
`define GAT_CAPTURE_ROW 5

`endif

/* design/gat_pkg.sv */
`include "gat_consts.svh"

package gat_pkg;

  typedef struct packed {
    logic                         last;  // closes the row.
    logic [`GAT_COL_W-1:0]        col;
    logic signed [`GAT_VAL_W-1:0] val;
  } sparse_entry_t;

  // same width as sparse_entry_t so both fit the one payload word.
  typedef struct packed {
    logic [`GAT_COL_W-1:0]        addr;
    logic signed [`GAT_VAL_W-1:0] wval;
    logic                         pad;
  } weight_cmd_t;

  typedef union packed {
    sparse_entry_t entry;
    weight_cmd_t   wload;
  } in_payload_u;

  typedef struct packed {
    logic        kind;  // 0 entry, 1 weight load.
    in_payload_u payload;
  } in_word_t;

  typedef struct packed {
    logic signed [`GAT_ACC_W-1:0] sum;
  } row_result_t;

  typedef struct packed {
    logic in_valid;
    logic in_ready;
    logic fifo_in_valid;
    logic fifo_in_ready;
    logic fifo_out_valid;
    logic fifo_out_ready;
    logic out_valid;
    logic out_ready;
  } link_flags_t;

  typedef struct packed {
    link_flags_t                  flags;
    logic [`GAT_CNT_W-1:0]        count;    // delivered features.
    logic signed [`GAT_OUT_W-1:0] capture;
  } debug_t;

endpackage

/* design/spmm_unit.sv */
`timescale 1ns/1ns
`include "gat_consts.svh"

module spmm_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid_i,
  input  gat_pkg::in_word_t    in_word_i,
  output logic                 in_ready_o,
  output logic                 res_valid_o,
  output gat_pkg::row_result_t res_o,
  input  logic                 res_ready_i
);

  import gat_pkg::*;

  localparam int tab_size = `GAT_TAB_SIZE;

  logic signed [`GAT_VAL_W-1:0] wtab [tab_size];
  logic signed [`GAT_ACC_W-1:0] acc_q;
  logic signed [`GAT_ACC_W-1:0] prod;
  logic signed [`GAT_ACC_W-1:0] acc_sum;
  logic                         res_pending_q;
  row_result_t                  res_q;
  sparse_entry_t                entry;
  weight_cmd_t                  wcmd;
  logic                         in_fire;
  logic                         entry_fire;
  logic                         wload_fire;
  logic                         row_done;

  // one payload word, read as either view depending on kind.
  assign entry = in_word_i.payload.entry;
  assign wcmd  = in_word_i.payload.wload;

  assign in_ready_o = !res_pending_q;  // stall while a row waits.
  assign in_fire    = in_valid_i && in_ready_o;
  assign entry_fire = in_fire && !in_word_i.kind;
  assign wload_fire = in_fire && in_word_i.kind;
  assign row_done   = entry_fire && entry.last;

  // operands are widened to the accumulator width before the multiply.
  assign prod    = $signed(entry.val) * wtab[entry.col];
  assign acc_sum = acc_q + prod;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < tab_size; i++) begin
        wtab[i] <= '0;
      end
    end else if (wload_fire) begin
      wtab[wcmd.addr] <= wcmd.wval;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q         <= '0;
      res_pending_q <= 1'b0;
    end else begin
      if (entry_fire) begin
        acc_q <= entry.last ? '0 : acc_sum;  // restart at row end.
      end
      if (row_done) begin
        res_pending_q <= 1'b1;
      end else if (res_valid_o && res_ready_i) begin
        res_pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_done) begin
      res_q.sum <= acc_sum;
    end
  end

  assign res_valid_o = res_pending_q;
  assign res_o       = res_q;

endmodule

/* design/row_fifo.sv */
`timescale 1ns/1ns
`include "gat_consts.svh"

module row_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push_valid_i,
  input  gat_pkg::row_result_t push_data_i,
  output logic                 push_ready_o,
  output logic                 pop_valid_o,
  output gat_pkg::row_result_t pop_data_o,
  input  logic                 pop_ready_i
);

  import gat_pkg::*;

  localparam int ptr_w = $clog2(`GAT_FIFO_DEPTH);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(`GAT_FIFO_DEPTH - 1);
  localparam logic [ptr_w:0] full_cnt = (ptr_w + 1)'(`GAT_FIFO_DEPTH);

  row_result_t      mem [`GAT_FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w:0]   cnt_q;
  logic             do_push;
  logic             do_pop;

  assign push_ready_o = (cnt_q != full_cnt);
  assign pop_valid_o  = (cnt_q != '0);
  assign pop_data_o   = mem[rd_ptr_q];  // head is shown as soon as written.

  assign do_push = push_valid_i && push_ready_o;
  assign do_pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == last_ptr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == last_ptr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // both or neither.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* design/aggr_unit.sv */
`timescale 1ns/1ns
`include "gat_consts.svh"

module aggr_unit (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid_i,
  input  gat_pkg::row_result_t         in_data_i,
  output logic                         in_ready_o,
  output logic                         out_valid_o,
  output logic signed [`GAT_OUT_W-1:0] out_feat_o,
  input  logic                         out_ready_i
);

  localparam logic signed [`GAT_ACC_W-1:0] feat_max = (2 ** (`GAT_OUT_W - 1)) - 1;

  logic signed [`GAT_OUT_W-1:0] sat_feat;
  logic signed [`GAT_OUT_W-1:0] out_feat_q;
  logic                         out_valid_q;
  logic                         in_fire;

  // relu, then clamp to the positive 16 bit range.
  always_comb begin
    if ($signed(in_data_i.sum) < 0) begin
      sat_feat = '0;
    end else if ($signed(in_data_i.sum) > feat_max) begin
      sat_feat = feat_max[`GAT_OUT_W-1:0];
    end else begin
      sat_feat = in_data_i.sum[`GAT_OUT_W-1:0];
    end
  end

  assign in_ready_o = !out_valid_q || out_ready_i;  // empty or draining.
  assign in_fire    = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (in_fire) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_feat_q <= sat_feat;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_feat_o  = out_feat_q;

endmodule

/* design/stage_monitor.sv */
`timescale 1ns/1ns
`include "gat_consts.svh"

module stage_monitor (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [3:0]                   link_valid_i,  // in, fifo_in, fifo_out, out.
  input  logic [3:0]                   link_ready_i,
  input  logic signed [`GAT_OUT_W-1:0] out_feat_i,
  output gat_pkg::debug_t              debug_o
);

  import gat_pkg::*;

  link_flags_t                  flags_seen;
  link_flags_t                  flags_q;
  logic [`GAT_CNT_W-1:0]        cnt_q;
  logic signed [`GAT_OUT_W-1:0] cap_q;
  logic                         out_fire;
  logic                         cap_hit;

  always_comb begin
    flags_seen.in_valid       = link_valid_i[0];
    flags_seen.in_ready       = link_ready_i[0];
    flags_seen.fifo_in_valid  = link_valid_i[1];
    flags_seen.fifo_in_ready  = link_ready_i[1];
    flags_seen.fifo_out_valid = link_valid_i[2];
    flags_seen.fifo_out_ready = link_ready_i[2];
    flags_seen.out_valid      = link_valid_i[3];
    flags_seen.out_ready      = link_ready_i[3];
  end

  assign out_fire = link_valid_i[3] && link_ready_i[3];
  // count still holds the index of the row being delivered.
  assign cap_hit  = out_fire && (cnt_q == `GAT_CAPTURE_ROW);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
      cnt_q   <= '0;
      cap_q   <= '0;
    end else begin
      flags_q <= flags_q | flags_seen;  // sticky until reset.
      if (out_fire) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (cap_hit) begin
        cap_q <= out_feat_i;
      end
    end
  end

  always_comb begin
    debug_o.flags   = flags_q;
    debug_o.count   = cnt_q;
    debug_o.capture = cap_q;
  end

endmodule

/* design/gat_core.sv */
`timescale 1ns/1ns
`include "gat_consts.svh"

module gat_core (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid_i,
  input  gat_pkg::in_word_t            in_word_i,
  output logic                         in_ready_o,
  output logic                         out_valid_o,
  output logic signed [`GAT_OUT_W-1:0] out_feat_o,
  input  logic                         out_ready_i,
  output gat_pkg::debug_t              debug_o
);

  import gat_pkg::*;

  logic        res_valid;
  row_result_t res_data;
  logic        fifo_push_ready;
  logic        fifo_pop_valid;
  row_result_t fifo_pop_data;
  logic        aggr_in_ready;

  spmm_unit i_spmm_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_word_i   (in_word_i),
    .in_ready_o  (in_ready_o),
    .res_valid_o (res_valid),
    .res_o       (res_data),
    .res_ready_i (fifo_push_ready)
  );

  row_fifo i_row_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid_i (res_valid),
    .push_data_i  (res_data),
    .push_ready_o (fifo_push_ready),
    .pop_valid_o  (fifo_pop_valid),
    .pop_data_o   (fifo_pop_data),
    .pop_ready_i  (aggr_in_ready)
  );

  aggr_unit i_aggr_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (fifo_pop_valid),
    .in_data_i   (fifo_pop_data),
    .in_ready_o  (aggr_in_ready),
    .out_valid_o (out_valid_o),
    .out_feat_o  (out_feat_o),
    .out_ready_i (out_ready_i)
  );

  // link order is out, fifo_out, fifo_in, in from msb down.
  stage_monitor i_stage_monitor (
    .clk          (clk),
    .rst_n        (rst_n),
    .link_valid_i ({out_valid_o, fifo_pop_valid, res_valid, in_valid_i}),
    .link_ready_i ({out_ready_i, aggr_in_ready, fifo_push_ready, in_ready_o}),
    .out_feat_i   (out_feat_o),
    .debug_o      (debug_o)
  );

endmodule

/* include/tb_gat_consts.svh */
`ifndef TB_GAT_CONSTS_SVH
`define TB_GAT_CONSTS_SVH

// rows sent in one run and the rows built to hit the clamps.
`define TB_NUM_ROWS     12
`define TB_HIGH_ROW     3
`define TB_NEG_ROW      7

`define TB_TIMEOUT      2000

`endif

/* verification/tb_gat_core.sv */
`timescale 1ns/1ns
`include "gat_consts.svh"
`include "tb_gat_consts.svh"

module tb_gat_core;

  import gat_pkg::*;

  logic                         clk;
  logic                         rst_n;
  logic                         in_valid_i;
  in_word_t                     in_word_i;
  logic                         in_ready_o;
  logic                         out_valid_o;
  logic signed [`GAT_OUT_W-1:0] out_feat_o;
  logic                         out_ready_i;
  debug_t                       debug_o;

  int                           tb_wtab [`GAT_TAB_SIZE];
  int                           exp_q [$];
  int                           delivered;
  int                           ready_odds;
  logic                         hold_ready;
  int                           cap_exp;
  logic                         cap_seen;
  logic                         prev_hold;
  logic signed [`GAT_OUT_W-1:0] prev_feat;

  gat_core i_gat_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_word_i   (in_word_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_feat_o  (out_feat_o),
    .out_ready_i (out_ready_i),
    .debug_o     (debug_o)
  );

  always #4 clk = ~clk;

  task automatic stop_on_mismatch(input string msg);
    $display("error %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "check failed");
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at %0t: gave up waiting for %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "run did not finish");
  endtask

  // relu and 16 bit saturation of a row sum.
  function automatic int clamp_feature(input int sum);
    if (sum < 0) begin
      return 0;
    end
    if (sum > 32767) begin
      return 32767;
    end
    return sum;
  endfunction

  // called on a falling edge, returns on the falling edge after the transfer.
  task automatic send_word(input in_word_t w);
    int waited;
    waited = 0;
    in_valid_i = 1'b1;
    in_word_i  = w;
    while (!in_ready_o) begin
      @(negedge clk);
      waited++;
      if (waited > `TB_TIMEOUT) begin
        stop_on_timeout("in_ready_o");
      end
    end
    @(negedge clk);
    in_valid_i = 1'b0;
  endtask

  task automatic idle_gap();
    repeat ($urandom_range(2, 0)) @(negedge clk);
  endtask

  task automatic load_weights();
    in_word_t w;
    int       r;
    for (int i = 0; i < `GAT_TAB_SIZE; i++) begin
      r = $urandom;
      w = '0;
      w.kind              = 1'b1;
      w.payload.wload.addr = i[`GAT_COL_W-1:0];
      w.payload.wload.wval = (i == 0) ? 8'sd127 : r[`GAT_VAL_W-1:0];  // col 0 drives the clamps.
      tb_wtab[i] = w.payload.wload.wval;
      idle_gap();
      send_word(w);
    end
  endtask

  task automatic send_row(input int row);
    in_word_t w;
    int       n;
    int       r;
    int       sum;
    sum = 0;
    if (row == `TB_HIGH_ROW) begin
      n = 6;
    end else if (row == `TB_NEG_ROW) begin
      n = 3;
    end else begin
      n = $urandom_range(6, 1);
    end
    for (int e = 0; e < n; e++) begin
      r = $urandom;
      w = '0;
      w.payload.entry.last = (e == n - 1);
      if (row == `TB_HIGH_ROW) begin
        w.payload.entry.val = 8'sd127;  // 6 * 127 * 127 overflows 16 bits.
      end else if (row == `TB_NEG_ROW) begin
        w.payload.entry.val = -8'sd100;
      end else begin
        w.payload.entry.col = r[`GAT_COL_W-1:0];
        w.payload.entry.val = r[`GAT_COL_W+`GAT_VAL_W-1:`GAT_COL_W];
      end
      sum += int'(w.payload.entry.val) * tb_wtab[w.payload.entry.col];
      if (e == n - 1) begin
        exp_q.push_back(clamp_feature(sum));
      end
      idle_gap();
      send_word(w);
    end
  endtask

  // output side: checks first, then the ready for the coming edge.
  always @(negedge clk) begin : out_side
    int exp_feat;
    if (rst_n) begin
      assert (debug_o.count == delivered[`GAT_CNT_W-1:0])
        else stop_on_mismatch($sformatf("count %0d, expected %0d", debug_o.count, delivered));
      if (prev_hold) begin
        assert (out_valid_o && out_feat_o == prev_feat)
          else stop_on_mismatch("output dropped or changed while stalled");
      end
      if (cap_seen) begin
        assert (debug_o.capture == cap_exp)
          else stop_on_mismatch($sformatf("capture %0d, expected %0d",
                                          debug_o.capture, cap_exp));
      end
      out_ready_i = !hold_ready && ($urandom_range(ready_odds - 1, 0) == 0);
      if (out_valid_o && out_ready_i) begin
        assert (exp_q.size() > 0)
          else stop_on_mismatch("extra output with no row pending");
        exp_feat = exp_q.pop_front();
        assert (out_feat_o == exp_feat)
          else stop_on_mismatch($sformatf("row %0d feature %0d, expected %0d",
                                          delivered, out_feat_o, exp_feat));
        if (delivered == `GAT_CAPTURE_ROW) begin
          cap_exp  = exp_feat;
          cap_seen = 1'b1;  // visible from the next falling edge.
        end
        delivered++;
      end
      prev_hold = out_valid_o && !out_ready_i;
      prev_feat = out_feat_o;
    end
  end

  task automatic wait_all_delivered();
    int waited;
    waited = 0;
    while (delivered < `TB_NUM_ROWS) begin
      @(negedge clk);
      waited++;
      if (waited > `TB_TIMEOUT) begin
        stop_on_timeout("all rows at the output");
      end
    end
  endtask

  initial begin
    void'($urandom(87716));
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_valid_i  = 1'b0;
    in_word_i   = '0;
    out_ready_i = 1'b0;
    delivered   = 0;
    ready_odds  = 8;  // slow drain.
    hold_ready  = 1'b1;
    cap_exp     = 0;
    cap_seen    = 1'b0;
    prev_hold   = 1'b0;
    prev_feat   = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (!out_valid_o && in_ready_o && debug_o == '0)
      else stop_on_mismatch("outputs not at reset values");
    load_weights();
    for (int row = 0; row < `TB_NUM_ROWS; row++) begin
      if (row == 6) begin
        hold_ready = 1'b0;  // rows 0 to 5 fill the pipe and the FIFO.
      end
      if (row == 8) begin
        ready_odds = 2;
      end
      send_row(row);
    end
    wait_all_delivered();
    repeat (2) @(negedge clk);
    assert (exp_q.size() == 0)
      else stop_on_mismatch("rows still expected at the end");
    assert (debug_o.flags == '1)
      else stop_on_mismatch($sformatf("flags %b, expected all set", debug_o.flags));
    assert (cap_seen)
      else stop_on_mismatch("captured row was never delivered");
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* list.f */
+incdir+include
design/gat_pkg.sv
design/spmm_unit.sv
design/row_fifo.sv
design/aggr_unit.sv
design/stage_monitor.sv
design/gat_core.sv
verification/tb_gat_core.sv

/* Makefile */
# Verilator build for the GAT core testbench.
# A failing check ends in $fatal, so the run target's exit status is the result.

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_gat_core
FILELIST = list.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
